// File: butterfly/butterfly_lane.sv
//**************************************************************************
// one butterfly lane: x = a + w*b, y = a - w*b mod q, or x = n_inv*b
// when scaling, three cycles issue to result
//**************************************************************************

module butterfly_lane import intt_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   issue,
    input  logic   scale,
    input  coeff_t a_in,
    input  coeff_t b_in,
    input  coeff_t factor,
    input  addr_t  wr_a_in,
    input  addr_t  wr_b_in,
    output logic   wb_valid,
    output logic   wb_scale,
    output coeff_t x_out,
    output coeff_t y_out,
    output addr_t  wr_a_out,
    output addr_t  wr_b_out
);

    logic [lane_delay-1:0] valid_q;           // issue pipeline
    logic [lane_delay-1:0] scale_q;
    addr_t                 wr_a_q [lane_delay];
    addr_t                 wr_b_q [lane_delay];
    coeff_t                a_q    [mul_delay];  // a waits for the product
    coeff_t                mul_y;
    coeff_t                prod;
    logic   [data_w:0]     sum;
    logic   [data_w:0]     diff;

    assign mul_y = scale ? coeff_t'(n_inv) : factor;    // lane picks 1/n itself

    mod_mul u_mul (
        .clk(clk), .reset(reset),
        .x(b_in), .y(mul_y), .p(prod)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            scale_q <= '0;
        end else begin
            valid_q <= {valid_q[lane_delay-2:0], issue};
            scale_q <= {scale_q[lane_delay-2:0], scale};
        end
    end

    always_ff @(posedge clk) begin
        wr_a_q[0] <= wr_a_in;
        wr_b_q[0] <= wr_b_in;
        for (int i = 1; i < lane_delay; i++) begin
            wr_a_q[i] <= wr_a_q[i-1];
            wr_b_q[i] <= wr_b_q[i-1];
        end
        a_q[0] <= a_in;
        for (int i = 1; i < mul_delay; i++) begin
            a_q[i] <= a_q[i-1];
        end
    end

    // mod add / sub, one conditional subtract each
    assign sum  = {1'b0, a_q[mul_delay-1]} + {1'b0, prod};
    assign diff = {1'b0, a_q[mul_delay-1]} + (data_w + 1)'(modulus) - {1'b0, prod};

    always_ff @(posedge clk) begin
        if (scale_q[mul_delay-1]) begin
            x_out <= prod;                    // a unused when scaling
        end else begin
            x_out <= (sum >= modulus) ? coeff_t'(sum - modulus) : coeff_t'(sum);
        end
        y_out <= (diff >= modulus) ? coeff_t'(diff - modulus) : coeff_t'(diff);
    end

    assign wb_valid = valid_q[lane_delay-1];
    assign wb_scale = scale_q[lane_delay-1];
    assign wr_a_out = wr_a_q[lane_delay-1];
    assign wr_b_out = wr_b_q[lane_delay-1];

endmodule

// File: butterfly/mod_mul.sv
//**************************************************************************
// two-cycle modular multiplier, plain product then remainder
//**************************************************************************

module mod_mul import intt_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  coeff_t x,
    input  coeff_t y,
    output coeff_t p              // x*y mod q, two cycles later
);

    logic [2*data_w-1:0] prod_q;   // full integer product

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_q <= '0;
            p      <= '0;
        end else begin
            prod_q <= x * y;                       // cycle 1
            p      <= coeff_t'(prod_q % modulus);  // cycle 2, plain remainder
        end
    end

endmodule

// File: common/intt_pkg.sv
//**************************************************************************
// shared constants and types for the 16-point inverse ntt engine
//**************************************************************************

package intt_pkg;

    // ring geometry
    localparam int ring_size  = 16;            // coefficients per vector
    localparam int log_ring   = 4;             // stages, also address width

    // arithmetic
    localparam int modulus    = 17;            // prime q
    localparam int data_w     = 5;             // bits per coefficient, holds 0..16

    // fixed constants of the ring, mod q
    localparam int n_inv      = 16;            // 16 * 16 = 256 = 1 mod 17
    localparam int w_inv      = 6;             // inverse primitive 16th root
    // 6^2 = 2, 6^4 = 4, 6^8 = 16 = -1, so order 16

    // datapath organisation
    localparam int lane_count = 2;             // butterflies issued per cycle

    // pipeline timing
    localparam int mul_delay  = 2;             // product reg + remainder reg
    localparam int lane_delay = 3;             // mul_delay + add/sub reg

    // one coefficient mod q
    typedef logic [data_w-1:0] coeff_t;

    // one coefficient address
    typedef logic [log_ring-1:0] addr_t;

endpackage

// File: dv/intt_ref.svh
//**************************************************************************
// reference inverse ntt over z_q and the lcg for random stimulus
//**************************************************************************

`ifndef INTT_REF_SVH
`define INTT_REF_SVH

// base^e mod q, plain repeated multiply
function automatic int pow_mod(input int base, input int e);
    int acc;
    acc = 1;
    for (int k = 0; k < e; k++) begin
        acc = (acc * base) % modulus;
    end
    return acc;
endfunction

// out[i] = n_inv * sum_j v[j] * w_inv^(i*j) mod q, straight from the definition
function automatic int intt_word(input int v [ring_size], input int i);
    int acc;
    acc = 0;
    for (int j = 0; j < ring_size; j++) begin
        acc = (acc + v[j] * pow_mod(w_inv, (i * j) % ring_size)) % modulus;  // w^16 = 1
    end
    return (acc * n_inv) % modulus;
endfunction

// 32-bit lcg step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: dv/intt_tb.sv
//**************************************************************************
// intt engine testbench with impulse and random runs against the reference,
// strobes while busy, output protocol assertions and a watchdog
//**************************************************************************

module intt_tb import intt_pkg::*; ();

    localparam int num_runs   = 9;       // impulse + 8 random
    localparam int run_cycles = 200;     // loose bound per run

    logic   clk;
    logic   reset;
    logic   load_valid;
    coeff_t load_data;
    logic   start;
    logic   busy;
    logic   out_valid;
    coeff_t out_data;
    logic   done;

    int          in_vec  [ring_size];    // natural order input
    int          exp_vec [ring_size];    // reference result of the current run
    string       test_name;
    logic [31:0] seed;
    int          data_errs;
    int          proto_errs;
    int          out_idx;                // words seen in the current burst

    `include "intt_ref.svh"

    intt_top UUT (
        .clk(clk), .reset(reset),
        .load_valid(load_valid), .load_data(load_data),
        .start(start), .busy(busy),
        .out_valid(out_valid), .out_data(out_data), .done(done)
    );

    always #2 clk = ~clk;

    // outputs quiet while reset held
    assert property (@(posedge clk) reset |-> !busy && !out_valid && !done)
        else begin
            proto_errs++;
            $display("ERR %s: busy,out_valid,done in reset exp 000 got %0b%0b%0b",
                     test_name, busy, out_valid, done);
        end

    // busy rises on an accepted start
    assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
        else begin
            proto_errs++;
            $display("ERR %s: busy after start exp 1 got %0b", test_name, busy);
        end

    // done never without a word
    assert property (@(posedge clk) disable iff (reset) done |-> out_valid)
        else begin
            proto_errs++;
            $display("ERR %s: out_valid with done exp 1 got %0b", test_name, out_valid);
        end

    // busy drops right after done and only then
    assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else begin
            proto_errs++;
            $display("ERR %s: busy after done exp 0 got %0b", test_name, busy);
        end

    assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> $past(done))
        else begin
            proto_errs++;
            $display("ERR %s: done before busy fell exp 1 got 0", test_name);
        end

    // output monitor sees pre-edge values
    always @(posedge clk) begin
        if (reset) begin
            out_idx = 0;
        end else if (out_valid) begin
            assert (out_idx < ring_size) else begin
                proto_errs++;
                $display("ERR %s: burst length exp %0d got %0d", test_name, ring_size,
                         out_idx + 1);
            end
            if (out_idx < ring_size) begin
                assert (out_data == coeff_t'(exp_vec[out_idx])) else begin
                    data_errs++;
                    $display("ERR %s word %0d: exp %0d got %0d", test_name, out_idx,
                             exp_vec[out_idx], out_data);
                end
            end
            assert (done == (out_idx == ring_size - 1)) else begin   // only on 16th
                proto_errs++;
                $display("ERR %s: done at word %0d exp %0b got %0b", test_name, out_idx,
                         out_idx == ring_size - 1, done);
            end
            out_idx++;
        end else begin
            assert (out_idx == 0 || out_idx == ring_size) else begin  // burst cut short
                proto_errs++;
                $display("ERR %s: burst length exp %0d got %0d", test_name, ring_size,
                         out_idx);
            end
            out_idx = 0;
        end
    end

    // next random coefficient in 0..q-1
    function automatic int draw_coeff();
        seed = lcg_next(seed);
        return int'(seed[31:16]) % modulus;
    endfunction

    // 16 loads in natural order then a start strobe
    task automatic load_and_start();
        for (int i = 0; i < ring_size; i++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_data  <= coeff_t'(in_vec[i]);
        end
        @(posedge clk);
        load_valid <= 1'b0;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // start and load together while the engine is busy
    task automatic poke_busy();
        @(posedge clk);
        start      <= 1'b1;
        load_valid <= 1'b1;
        load_data  <= coeff_t'(draw_coeff());
        @(posedge clk);
        start      <= 1'b0;
        load_valid <= 1'b0;
    endtask

    task automatic run_vector(input string name, input bit poke);
        test_name = name;
        for (int i = 0; i < ring_size; i++) begin
            exp_vec[i] = intt_word(in_vec, i);
        end
        load_and_start();
        if (poke) begin
            repeat (3) @(posedge clk);
            poke_busy();                  // during stage 0
            repeat (17) @(posedge clk);
            poke_busy();                  // later stage
            do begin
                @(posedge clk);
            end while (!out_valid);
            poke_busy();                  // inside output burst
        end
        do begin
            @(posedge clk);
        end while (!done);
        @(posedge clk);                   // busy low from here
    endtask

    // watchdog
    initial begin
        repeat (num_runs * run_cycles + 100) @(posedge clk);
        $display("timeout: engine never finished, run stopped after %0d cycles",
                 num_runs * run_cycles + 100);
        $display("errors: data %0d protocol %0d", data_errs, proto_errs);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        load_valid = 1'b0;
        load_data  = '0;
        start      = 1'b0;
        seed       = 32'h6d94_c552;
        data_errs  = 0;
        proto_errs = 0;
        test_name  = "reset";

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!busy && !out_valid && !done) else begin
            proto_errs++;
            $display("ERR %s: busy,out_valid,done after reset exp 000 got %0b%0b%0b",
                     test_name, busy, out_valid, done);
        end

        // impulse at index 0 gives n_inv everywhere
        for (int i = 0; i < ring_size; i++) begin
            in_vec[i] = (i == 0) ? 1 : 0;
        end
        run_vector("impulse", 1'b0);

        // random vectors with busy strobes during random_3
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < ring_size; i++) begin
                in_vec[i] = draw_coeff();
            end
            run_vector($sformatf("random_%0d", r), r == 3);
        end

        repeat (4) @(posedge clk);
        $display("errors: data %0d protocol %0d", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rtl/coeff_store.sv
//**************************************************************************
// 16-word coefficient register file: bit-reversed load, two-lane
// write-back merge, four butterfly reads and one output read
//**************************************************************************

module coeff_store import intt_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   load_en,
    input  addr_t  load_addr,      // natural index
    input  coeff_t load_data,
    input  addr_t  rd_addr_0,
    input  addr_t  rd_addr_1,
    input  addr_t  rd_addr_2,
    input  addr_t  rd_addr_3,
    output coeff_t rd_data_0,
    output coeff_t rd_data_1,
    output coeff_t rd_data_2,
    output coeff_t rd_data_3,
    input  logic   wb_valid_0,
    input  logic   wb_scale_0,
    input  coeff_t x_0,
    input  coeff_t y_0,
    input  addr_t  wr_a_0,
    input  addr_t  wr_b_0,
    input  logic   wb_valid_1,
    input  logic   wb_scale_1,
    input  coeff_t x_1,
    input  coeff_t y_1,
    input  addr_t  wr_a_1,
    input  addr_t  wr_b_1,
    input  addr_t  out_addr,
    output coeff_t out_data
);

    coeff_t mem [ring_size];

    function automatic addr_t bit_rev(input addr_t a);
        addr_t r;
        for (int i = 0; i < log_ring; i++) begin
            r[i] = a[log_ring - 1 - i];
        end
        return r;
    endfunction

    // load only happens idle, write-back only busy, so no overlap
    // lanes touch disjoint words within a stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ring_size; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (load_en) mem[bit_rev(load_addr)] <= load_data;   // dit wants bit-reversed in
            if (wb_valid_0) begin
                mem[wr_a_0] <= x_0;
                if (!wb_scale_0) mem[wr_b_0] <= y_0;             // scale writes a only
            end
            if (wb_valid_1) begin
                mem[wr_a_1] <= x_1;
                if (!wb_scale_1) mem[wr_b_1] <= y_1;
            end
        end
    end

    // combinational reads
    assign rd_data_0 = mem[rd_addr_0];
    assign rd_data_1 = mem[rd_addr_1];
    assign rd_data_2 = mem[rd_addr_2];
    assign rd_data_3 = mem[rd_addr_3];
    assign out_data  = mem[out_addr];     // natural order out

endmodule

// File: rtl/intt_ctrl.sv
//**************************************************************************
// intt controller: run fsm, load/step counters, dit butterfly addressing,
// scale pass and output sequencing
//**************************************************************************

module intt_ctrl import intt_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  load_valid,
    input  logic                                  start,
    output logic                                  busy,
    output logic                                  out_valid,
    output logic                                  done,
    output logic                                  load_en,
    output addr_t                                 load_addr,
    output logic   [lane_count-1:0]               issue,
    output logic                                  scale,
    output addr_t  [lane_count-1:0]               rd_addr_a,
    output addr_t  [lane_count-1:0]               rd_addr_b,
    output addr_t  [lane_count-1:0]               wr_addr_a,
    output addr_t  [lane_count-1:0]               wr_addr_b,
    output logic   [lane_count-1:0][log_ring-2:0] tw_exp,
    output addr_t                                 out_addr
);

    typedef enum logic [2:0] {
        idle_s,
        stage_s,          // butterflies of one dit stage
        drain_s,          // wait for lane results
        scale_s,          // multiply by n_inv
        scale_drain_s,
        out_s             // stream natural order
    } state_t;

    state_t                      state;
    addr_t                       cnt;          // step counter, reused per state
    addr_t                       load_cnt;     // natural load index, wraps
    logic [$clog2(log_ring)-1:0] stage_idx;    // current dit stage
    logic [log_ring-2:0]         span_mask;    // span - 1 for this stage
    logic                        issuing;

    // load path, only while idle
    assign load_en   = load_valid && !busy;
    assign load_addr = load_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_cnt <= '0;
        end else if (load_en) begin
            load_cnt <= load_cnt + 1'b1;           // wraps after 16
        end
    end

    // run fsm
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= idle_s;
            cnt       <= '0;
            stage_idx <= '0;
        end else begin
            case (state)
                idle_s: begin
                    cnt       <= '0;
                    stage_idx <= '0;
                    if (start) state <= stage_s;
                end
                stage_s: begin
                    if (cnt == addr_t'(ring_size / (2 * lane_count) - 1)) begin
                        cnt   <= '0;
                        state <= drain_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                drain_s: begin
                    if (cnt == addr_t'(lane_delay - 1)) begin
                        cnt <= '0;
                        if (stage_idx == log_ring - 1) begin
                            state <= scale_s;      // all stages written back
                        end else begin
                            stage_idx <= stage_idx + 1'b1;
                            state     <= stage_s;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                scale_s: begin
                    if (cnt == addr_t'(ring_size / lane_count - 1)) begin
                        cnt   <= '0;
                        state <= scale_drain_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                scale_drain_s: begin
                    if (cnt == addr_t'(lane_delay - 1)) begin
                        cnt   <= '0;
                        state <= out_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                out_s: begin
                    if (cnt == addr_t'(ring_size - 1)) begin
                        cnt   <= '0;
                        state <= idle_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= idle_s;
            endcase
        end
    end

    assign busy      = (state != idle_s);
    assign scale     = (state == scale_s);
    assign issuing   = (state == stage_s) || scale;
    assign out_valid = (state == out_s);
    assign done      = out_valid && (cnt == addr_t'(ring_size - 1));   // last word
    assign out_addr  = cnt;

    // stage 0 -> 000, stage 3 -> 111
    assign span_mask = ~({(log_ring - 1){1'b1}} << stage_idx);

    for (genvar l = 0; l < lane_count; l++) begin : g_lane
        logic [log_ring-2:0] bf_idx;    // butterfly number within the stage
        logic [log_ring-2:0] pos;       // offset inside the group
        logic [log_ring-2:0] exp;
        addr_t               top_addr;
        addr_t               bot_addr;
        addr_t               scale_addr;

        assign bf_idx     = (log_ring - 1)'(cnt * lane_count + l);    // lanes interleave
        assign pos        = bf_idx & span_mask;
        // group * 2 * span + pos, bit stage_idx left clear
        assign top_addr   = {bf_idx & ~span_mask, 1'b0} | addr_t'(pos);
        assign bot_addr   = top_addr | (addr_t'(1) << stage_idx);
        assign exp        = pos << (log_ring - 1 - stage_idx);        // pos * n / 2span
        assign scale_addr = addr_t'(cnt * lane_count + l);

        assign issue[l]     = issuing;
        assign rd_addr_a[l] = scale ? scale_addr : top_addr;
        assign rd_addr_b[l] = scale ? scale_addr : bot_addr;     // product uses b
        assign wr_addr_a[l] = rd_addr_a[l];                      // in place
        assign wr_addr_b[l] = rd_addr_b[l];
        assign tw_exp[l]    = scale ? '0 : exp;
    end

endmodule

// File: rtl/intt_top.sv
//**************************************************************************
// inverse ntt engine top: controller, twiddle table, two lanes, store
//**************************************************************************

module intt_top import intt_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   load_valid,     // one word per strobe, natural order
    input  coeff_t load_data,
    input  logic   start,
    output logic   busy,
    output logic   out_valid,
    output coeff_t out_data,
    output logic   done
);

    logic                                  load_en;
    addr_t                                 load_addr;
    logic   [lane_count-1:0]               issue;
    logic                                  scale;
    addr_t  [lane_count-1:0]               rd_addr_a;
    addr_t  [lane_count-1:0]               rd_addr_b;
    addr_t  [lane_count-1:0]               wr_addr_a;
    addr_t  [lane_count-1:0]               wr_addr_b;
    logic   [lane_count-1:0][log_ring-2:0] tw_exp;
    addr_t                                 out_addr;

    coeff_t factor_0, factor_1;                    // twiddles per lane
    coeff_t rd_data_0, rd_data_1;                  // lane 0 a, b
    coeff_t rd_data_2, rd_data_3;                  // lane 1 a, b

    // lane write-back buses
    logic   wb_valid_0, wb_scale_0, wb_valid_1, wb_scale_1;
    coeff_t x_0, y_0, x_1, y_1;
    addr_t  wr_a_0, wr_b_0, wr_a_1, wr_b_1;

    intt_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .load_valid(load_valid), .start(start),
        .busy(busy), .out_valid(out_valid), .done(done),
        .load_en(load_en), .load_addr(load_addr),
        .issue(issue), .scale(scale),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .wr_addr_a(wr_addr_a), .wr_addr_b(wr_addr_b),
        .tw_exp(tw_exp), .out_addr(out_addr)
    );

    twiddle_rom u_twiddle (
        .tw_exp_0(tw_exp[0]), .tw_exp_1(tw_exp[1]),
        .factor_0(factor_0),  .factor_1(factor_1)
    );

    butterfly_lane u_lane_0 (
        .clk(clk), .reset(reset),
        .issue(issue[0]), .scale(scale),
        .a_in(rd_data_0), .b_in(rd_data_1), .factor(factor_0),
        .wr_a_in(wr_addr_a[0]), .wr_b_in(wr_addr_b[0]),
        .wb_valid(wb_valid_0), .wb_scale(wb_scale_0),
        .x_out(x_0), .y_out(y_0), .wr_a_out(wr_a_0), .wr_b_out(wr_b_0)
    );

    butterfly_lane u_lane_1 (
        .clk(clk), .reset(reset),
        .issue(issue[1]), .scale(scale),
        .a_in(rd_data_2), .b_in(rd_data_3), .factor(factor_1),
        .wr_a_in(wr_addr_a[1]), .wr_b_in(wr_addr_b[1]),
        .wb_valid(wb_valid_1), .wb_scale(wb_scale_1),
        .x_out(x_1), .y_out(y_1), .wr_a_out(wr_a_1), .wr_b_out(wr_b_1)
    );

    coeff_store u_store (
        .clk(clk), .reset(reset),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .rd_addr_0(rd_addr_a[0]), .rd_addr_1(rd_addr_b[0]),
        .rd_addr_2(rd_addr_a[1]), .rd_addr_3(rd_addr_b[1]),
        .rd_data_0(rd_data_0), .rd_data_1(rd_data_1),
        .rd_data_2(rd_data_2), .rd_data_3(rd_data_3),
        .wb_valid_0(wb_valid_0), .wb_scale_0(wb_scale_0), .x_0(x_0), .y_0(y_0),
        .wr_a_0(wr_a_0), .wr_b_0(wr_b_0),
        .wb_valid_1(wb_valid_1), .wb_scale_1(wb_scale_1), .x_1(x_1), .y_1(y_1),
        .wr_a_1(wr_a_1), .wr_b_1(wr_b_1),
        .out_addr(out_addr), .out_data(out_data)
    );

endmodule

// File: rtl/twiddle_rom.sv
//**************************************************************************
// dual-read table of w_inv^e mod q, e = 0..7
//**************************************************************************

module twiddle_rom import intt_pkg::*; (
    input  logic [log_ring-2:0] tw_exp_0,
    input  logic [log_ring-2:0] tw_exp_1,
    output coeff_t              factor_0,
    output coeff_t              factor_1
);

    coeff_t tw_table [ring_size / 2];

    // repeated multiply, evaluated at elaboration
    function automatic coeff_t tw_pow(input int e);
        int acc;
        acc = 1;
        for (int i = 0; i < e; i++) begin
            acc = (acc * w_inv) % modulus;
        end
        return coeff_t'(acc);
    endfunction

    for (genvar e = 0; e < ring_size / 2; e++) begin : g_entry
        assign tw_table[e] = tw_pow(e);
    end

    assign factor_0 = tw_table[tw_exp_0];
    assign factor_1 = tw_table[tw_exp_1];

endmodule

// File: run.sh
#!/bin/sh
# build the intt testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module intt_tb -f sim.f -o intt_sim \
    && ./obj_dir/intt_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+dv
common/intt_pkg.sv
butterfly/mod_mul.sv
butterfly/butterfly_lane.sv
rtl/twiddle_rom.sv
rtl/coeff_store.sv
rtl/intt_ctrl.sv
rtl/intt_top.sv
dv/intt_tb.sv
